//--- source/cache_pkg.sv
`default_nettype none

package cache_pkg;

	// address layout
	// ----------------------------------------------------------
	localparam int BW_WORD_ADDR    = 16;	// word address from the core
	localparam int BW_BLOCK        = 2;	// word-in-block bits
	localparam int WORDS_PER_BLOCK = 4;	// 2**BW_BLOCK

	// comm port, opcode in comm_i[31:28]
	// ----------------------------------------------------------
	localparam logic [3:0] COMM_OP_CLEAR = 4'h1;	// zero all counters
	localparam logic [3:0] COMM_OP_READ  = 4'h2;	// latch one counter to comm_o

	// counter select for COMM_OP_READ, comm_i[1:0]
	localparam logic [1:0] COMM_SEL_HIT  = 2'd0;
	localparam logic [1:0] COMM_SEL_MISS = 2'd1;
	localparam logic [1:0] COMM_SEL_WB   = 2'd2;

endpackage

`default_nettype wire

//--- source/cache_tag_memory.sv
`timescale 1ns/1ps
`default_nettype none

module cache_tag_memory #(
	parameter CACHE_BLOCK_CAPACITY = 16,
	parameter CACHE_SET_SIZE       = 4,
	localparam N_WAY    = CACHE_SET_SIZE,
	localparam N_SET    = CACHE_BLOCK_CAPACITY / CACHE_SET_SIZE,
	localparam BW_SET   = $clog2(N_SET),
	localparam BW_SET_W = (BW_SET > 0) ? BW_SET : 1,
	localparam BW_WAY   = (N_WAY > 1) ? $clog2(N_WAY) : 1,
	localparam BW_TAG   = cache_pkg::BW_WORD_ADDR - cache_pkg::BW_BLOCK - BW_SET
)(
	input  wire                 clock_i,
	input  wire                 rst_n_i,
	input  wire  [BW_SET_W-1:0] set_i,		// set of the current request
	input  wire  [BW_TAG-1:0]   tag_i,		// tag of the current request
	input  wire                 wren_i,		// install tag_i at way_i
	input  wire  [BW_WAY-1:0]   way_i,
	input  wire                 dirty_wr_i,	// update dirty bit only
	input  wire                 dirty_i,
	output logic                hit_o,
	output logic [BW_WAY-1:0]   hit_way_o,
	output logic [BW_WAY-1:0]   victim_way_o,	// round-robin pick for this set
	output logic [BW_TAG-1:0]   victim_tag_o,
	output logic                victim_dirty_o
);

	// storage
	// ----------------------------------------------------------
	logic [BW_TAG-1:0] tag_mem [N_SET][N_WAY];	// no reset, qualified by valid
	logic [N_WAY-1:0]  valid_q [N_SET];
	logic [N_WAY-1:0]  dirty_q [N_SET];
	logic [BW_WAY-1:0] rr_q    [N_SET];		// next victim per set
	logic [N_WAY-1:0]  match;

	// parallel compare across the ways of one set
	always_comb begin
		match     = '0;
		hit_way_o = '0;
		for (int w = 0; w < N_WAY; w++) begin
			match[w] = valid_q[set_i][w] && (tag_mem[set_i][w] == tag_i);
			if (match[w])
				hit_way_o = BW_WAY'(w);
		end
	end

	assign hit_o          = |match;
	assign victim_way_o   = rr_q[set_i];
	assign victim_tag_o   = tag_mem[set_i][victim_way_o];
	assign victim_dirty_o = valid_q[set_i][victim_way_o] & dirty_q[set_i][victim_way_o];

	// state bits
	// ----------------------------------------------------------
	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int s = 0; s < N_SET; s++) begin
				valid_q[s] <= '0;
				dirty_q[s] <= '0;
				rr_q[s]    <= '0;
			end
		end else if (wren_i) begin
			valid_q[set_i][way_i] <= 1'b1;
			dirty_q[set_i][way_i] <= 1'b0;	// fresh fill is clean
			rr_q[set_i] <= (rr_q[set_i] == BW_WAY'(N_WAY - 1)) ? '0 : rr_q[set_i] + 1'b1;
		end else if (dirty_wr_i) begin
			dirty_q[set_i][way_i] <= dirty_i;
		end
	end

	always_ff @(posedge clock_i) begin
		if (wren_i)
			tag_mem[set_i][way_i] <= tag_i;
	end

	// a tag lives in at most one way of its set
	a_hit_onehot: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		$onehot0(match));

endmodule

`default_nettype wire

//--- source/cache_data_memory.sv
`timescale 1ns/1ps
`default_nettype none

module cache_data_memory #(
	parameter CACHE_BLOCK_CAPACITY = 16,
	localparam N_WORDS = CACHE_BLOCK_CAPACITY * cache_pkg::WORDS_PER_BLOCK,
	localparam BW_ADDR = $clog2(N_WORDS)
)(
	input  wire                clock_i,
	input  wire  [BW_ADDR-1:0] addr_i,	// {set, way, word}
	input  wire                wren_i,
	input  wire  [31:0]        data_i,
	output logic [31:0]        data_o	// one cycle after addr_i
);

	logic [31:0] mem [N_WORDS];

	// single port, read returns the old word on a write
	always_ff @(posedge clock_i) begin
		if (wren_i)
			mem[addr_i] <= data_i;
		data_o <= mem[addr_i];
	end

endmodule

`default_nettype wire

//--- source/cache_controller.sv
`timescale 1ns/1ps
`default_nettype none

module cache_controller #(
	parameter CACHE_BLOCK_CAPACITY = 16,
	parameter CACHE_SET_SIZE       = 4,
	localparam N_WAY       = CACHE_SET_SIZE,
	localparam N_SET       = CACHE_BLOCK_CAPACITY / CACHE_SET_SIZE,
	localparam BW_SET      = $clog2(N_SET),
	localparam BW_SET_W    = (BW_SET > 0) ? BW_SET : 1,
	localparam BW_WAY      = (N_WAY > 1) ? $clog2(N_WAY) : 1,
	localparam BW_TAG      = cache_pkg::BW_WORD_ADDR - cache_pkg::BW_BLOCK - BW_SET,
	localparam BW_LINE     = $clog2(CACHE_BLOCK_CAPACITY),
	localparam BW_MEM_ADDR = BW_LINE + cache_pkg::BW_BLOCK,
	localparam BW_BLK_ADDR = cache_pkg::BW_WORD_ADDR - cache_pkg::BW_BLOCK
)(
	input  wire                              clock_i,
	input  wire                              rst_n_i,
	input  wire                              en_i,		// low parks the FSM in idle

	// core side
	input  wire                              core_req_i,
	input  wire                              core_rw_i,	// 1 write
	input  wire  [BW_TAG-1:0]                core_tag_i,
	input  wire  [BW_SET_W-1:0]              core_set_i,
	input  wire  [cache_pkg::BW_BLOCK-1:0]   core_word_i,
	input  wire  [31:0]                      core_data_i,
	output logic                             core_done_o,
	output logic [31:0]                      core_data_o,
	output logic                             hit_o,

	// tag memory
	input  wire                              tag_hit_i,
	input  wire  [BW_WAY-1:0]                tag_hit_way_i,
	input  wire  [BW_WAY-1:0]                victim_way_i,
	input  wire  [BW_TAG-1:0]                victim_tag_i,
	input  wire                              victim_dirty_i,
	output logic                             tag_wren_o,
	output logic                             tag_dirty_wr_o,
	output logic [BW_WAY-1:0]                tag_way_o,
	output logic                             tag_dirty_val_o,

	// data memory
	input  wire  [31:0]                      mem_rdata_i,
	output logic [BW_MEM_ADDR-1:0]           mem_addr_o,
	output logic                             mem_wren_o,
	output logic [31:0]                      mem_wdata_o,

	// external buffer
	input  wire                              ready_req_i,
	input  wire                              ready_write_i,
	input  wire                              ready_read_i,
	input  wire  [31:0]                      data_i,
	output logic                             req_o,
	output logic                             rw_o,
	output logic                             write_o,
	output logic                             read_o,
	output logic [cache_pkg::BW_WORD_ADDR-1:0] add_o,
	output logic [31:0]                      data_o,

	// perf events, one cycle each
	output logic                             flag_hit_o,
	output logic                             flag_miss_o,
	output logic                             flag_wb_o
);

	localparam logic [2:0] S_IDLE      = 3'd0;
	localparam logic [2:0] S_LOOKUP    = 3'd1;
	localparam logic [2:0] S_RESPOND   = 3'd2;
	localparam logic [2:0] S_WB_CMD    = 3'd3;
	localparam logic [2:0] S_WB_DATA   = 3'd4;
	localparam logic [2:0] S_FILL_CMD  = 3'd5;
	localparam logic [2:0] S_FILL_DATA = 3'd6;
	localparam logic [2:0] S_REPLAY    = 3'd7;

	logic [2:0]                    state_q, state_d;
	logic [cache_pkg::BW_BLOCK-1:0] word_cnt_q;	// beat index in wb and fill
	logic                          hit_q;		// lookup hit, low on replay
	logic                          access;		// word access on the hit path
	logic                          write_fire, read_fire, last_word;
	logic [BW_WAY-1:0]             line_way;
	logic [cache_pkg::BW_BLOCK-1:0] mem_word;
	logic [BW_LINE-1:0]            line_idx;
	logic [BW_BLK_ADDR-1:0]        fill_blk, wb_blk;

	assign write_fire = (state_q == S_WB_DATA) && ready_write_i;
	assign read_fire  = (state_q == S_FILL_DATA) && ready_read_i;
	assign last_word  = &word_cnt_q;

	// block addresses, set bits vanish with a single set
	generate
		if (N_SET > 1) begin : g_set_addr
			assign fill_blk = {core_tag_i, core_set_i};
			assign wb_blk   = {victim_tag_i, core_set_i};
		end else begin : g_one_set
			assign fill_blk = core_tag_i;
			assign wb_blk   = victim_tag_i;
		end
	endgenerate

	// next state and datapath controls
	// ----------------------------------------------------------
	always_comb begin
		state_d         = state_q;
		access          = 1'b0;
		line_way        = victim_way_i;	// miss traffic targets the victim
		mem_word        = core_word_i;
		mem_wren_o      = 1'b0;
		mem_wdata_o     = core_data_i;
		tag_wren_o      = 1'b0;
		tag_dirty_wr_o  = 1'b0;
		tag_way_o       = victim_way_i;
		tag_dirty_val_o = 1'b1;		// only write hits touch dirty
		flag_hit_o      = 1'b0;
		flag_miss_o     = 1'b0;
		flag_wb_o       = 1'b0;
		case (state_q)
			S_IDLE: begin
				if (en_i && core_req_i)
					state_d = S_LOOKUP;
			end
			S_LOOKUP: begin
				if (tag_hit_i) begin
					access     = 1'b1;
					flag_hit_o = 1'b1;
					state_d    = S_RESPOND;
				end else begin
					flag_miss_o = 1'b1;
					flag_wb_o   = victim_dirty_i;
					state_d     = victim_dirty_i ? S_WB_CMD : S_FILL_CMD;
				end
			end
			S_REPLAY: begin
				access  = 1'b1;			// tag now installed
				state_d = S_RESPOND;
			end
			S_RESPOND: state_d = S_IDLE;
			S_WB_CMD: begin
				mem_word = '0;			// prefetch first victim word
				if (ready_req_i)
					state_d = S_WB_DATA;
			end
			S_WB_DATA: begin
				// keep read data one beat ahead of the buffer
				mem_word = write_fire ? word_cnt_q + 1'b1 : word_cnt_q;
				if (write_fire && last_word)
					state_d = S_FILL_CMD;
			end
			S_FILL_CMD: begin
				if (ready_req_i)
					state_d = S_FILL_DATA;
			end
			S_FILL_DATA: begin
				mem_word    = word_cnt_q;
				mem_wren_o  = read_fire;
				mem_wdata_o = data_i;
				if (read_fire && last_word) begin
					tag_wren_o = 1'b1;	// install with the last beat
					state_d    = S_REPLAY;
				end
			end
			default: state_d = S_IDLE;
		endcase
		if (access) begin
			line_way       = tag_hit_way_i;
			tag_way_o      = tag_hit_way_i;
			mem_wren_o     = core_rw_i;
			tag_dirty_wr_o = core_rw_i;
		end
	end

	assign line_idx   = BW_LINE'(core_set_i * N_WAY + line_way);
	assign mem_addr_o = {line_idx, mem_word};

	// outputs
	// ----------------------------------------------------------
	assign req_o       = (state_q == S_WB_CMD) || (state_q == S_FILL_CMD);
	assign rw_o        = state_q == S_WB_CMD;
	assign add_o       = {(rw_o ? wb_blk : fill_blk), {cache_pkg::BW_BLOCK{1'b0}}};
	assign write_o     = write_fire;
	assign read_o      = read_fire;
	assign data_o      = mem_rdata_i;
	assign core_done_o = state_q == S_RESPOND;
	assign hit_o       = core_done_o && hit_q;
	assign core_data_o = mem_rdata_i;

	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q    <= S_IDLE;
			word_cnt_q <= '0;
			hit_q      <= 1'b0;
		end else begin
			state_q <= state_d;
			if (state_q == S_LOOKUP) begin
				hit_q      <= tag_hit_i;
				word_cnt_q <= '0;
			end else if (write_fire || read_fire) begin
				word_cnt_q <= word_cnt_q + 1'b1;	// wraps to 0 between wb and fill
			end
		end
	end

	// checks
	// ----------------------------------------------------------
	a_wr_rd_excl: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		!(write_o && read_o));

	// command held with its address until accepted
	a_req_hold: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		req_o && !ready_req_i |=> req_o && $stable(add_o) && $stable(rw_o));

	// the fill must leave the tag memory hitting for the replay
	a_replay_hit: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		state_q == S_REPLAY |-> tag_hit_i);

endmodule

`default_nettype wire

//--- source/cache_perf_counter.sv
`timescale 1ns/1ps
`default_nettype none

module cache_perf_counter (
	input  wire         clock_i,
	input  wire         rst_n_i,
	input  wire         hit_i,		// one pulse per event
	input  wire         miss_i,
	input  wire         writeback_i,
	input  wire  [31:0] comm_i,
	output logic [31:0] comm_o		// registered readback
);

	logic [31:0] hit_cnt_q, miss_cnt_q, wb_cnt_q;
	logic [31:0] sel_cnt;
	logic        op_clear, op_read;

	// saturating increment
	function automatic logic [31:0] sat_inc(input logic [31:0] cnt, input logic ev);
		return (ev && !(&cnt)) ? cnt + 1'b1 : cnt;
	endfunction

	assign op_clear = comm_i[31:28] == cache_pkg::COMM_OP_CLEAR;
	assign op_read  = comm_i[31:28] == cache_pkg::COMM_OP_READ;

	always_comb begin
		case (comm_i[1:0])
			cache_pkg::COMM_SEL_HIT:  sel_cnt = hit_cnt_q;
			cache_pkg::COMM_SEL_MISS: sel_cnt = miss_cnt_q;
			cache_pkg::COMM_SEL_WB:   sel_cnt = wb_cnt_q;
			default:                  sel_cnt = '0;	// unused select
		endcase
	end

	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			hit_cnt_q  <= '0;
			miss_cnt_q <= '0;
			wb_cnt_q   <= '0;
			comm_o     <= '0;
		end else if (op_clear) begin
			hit_cnt_q  <= '0;		// clear beats a same-cycle event
			miss_cnt_q <= '0;
			wb_cnt_q   <= '0;
			comm_o     <= '0;
		end else begin
			hit_cnt_q  <= sat_inc(hit_cnt_q, hit_i);
			miss_cnt_q <= sat_inc(miss_cnt_q, miss_i);
			wb_cnt_q   <= sat_inc(wb_cnt_q, writeback_i);
			if (op_read)
				comm_o <= sel_cnt;	// otherwise hold last readback
		end
	end

endmodule

`default_nettype wire

//--- source/cache_n_set.sv
`timescale 1ns/1ps
`default_nettype none

module cache_n_set #(
	parameter CACHE_BLOCK_CAPACITY = 16,
	parameter CACHE_SET_SIZE       = 4
)(
	// system
	input  wire                                clock_i,
	input  wire                                rst_n_i,
	input  wire                                en_i,
	input  wire  [31:0]                        comm_i,	// generic comm in
	output logic [31:0]                        comm_o,

	// core
	input  wire                                core_req_i,
	input  wire                                core_rw_i,	// 1 write, 0 read
	input  wire  [cache_pkg::BW_WORD_ADDR-1:0] core_add_i,
	input  wire  [31:0]                        core_data_i,
	output logic                               core_done_o,
	output logic [31:0]                        core_data_o,
	output logic                               hit_o,

	// external buffer
	input  wire                                ready_req_i,
	input  wire                                ready_write_i,
	input  wire                                ready_read_i,
	input  wire  [31:0]                        data_i,
	output logic                               req_o,
	output logic                               rw_o,
	output logic                               write_o,
	output logic                               read_o,
	output logic [cache_pkg::BW_WORD_ADDR-1:0] add_o,	// block aligned
	output logic [31:0]                        data_o
);

	localparam N_SET       = CACHE_BLOCK_CAPACITY / CACHE_SET_SIZE;
	localparam BW_SET      = $clog2(N_SET);
	localparam BW_SET_W    = (BW_SET > 0) ? BW_SET : 1;
	localparam BW_WAY      = (CACHE_SET_SIZE > 1) ? $clog2(CACHE_SET_SIZE) : 1;
	localparam BW_TAG      = cache_pkg::BW_WORD_ADDR - cache_pkg::BW_BLOCK - BW_SET;
	localparam BW_MEM_ADDR = $clog2(CACHE_BLOCK_CAPACITY) + cache_pkg::BW_BLOCK;

	// address split [tag|set|word]
	// ----------------------------------------------------------
	logic [BW_TAG-1:0]              req_tag;
	logic [BW_SET_W-1:0]            req_set;
	logic [cache_pkg::BW_BLOCK-1:0] req_word;

	assign req_tag  = core_add_i[cache_pkg::BW_WORD_ADDR-1 -: BW_TAG];
	assign req_word = core_add_i[cache_pkg::BW_BLOCK-1:0];

	generate
		if (N_SET > 1) begin : g_set
			assign req_set = core_add_i[cache_pkg::BW_BLOCK +: BW_SET_W];
		end else begin : g_no_set
			assign req_set = '0;		// fully associative
		end
	endgenerate

	// internal nets
	// ----------------------------------------------------------
	logic                   tag_wren, tag_dirty_wr, tag_dirty_val;
	logic [BW_WAY-1:0]      tag_way, tag_hit_way, victim_way;
	logic                   tag_hit, victim_dirty;
	logic [BW_TAG-1:0]      victim_tag;
	logic [BW_MEM_ADDR-1:0] mem_addr;
	logic                   mem_wren;
	logic [31:0]            mem_wdata, mem_rdata;
	logic                   flag_hit, flag_miss, flag_wb;

	cache_tag_memory #(
		.CACHE_BLOCK_CAPACITY	(CACHE_BLOCK_CAPACITY),
		.CACHE_SET_SIZE		(CACHE_SET_SIZE)
	) u_tag_memory (
		.clock_i		(clock_i),
		.rst_n_i		(rst_n_i),
		.set_i			(req_set),
		.tag_i			(req_tag),
		.wren_i			(tag_wren),		// install on fill
		.way_i			(tag_way),
		.dirty_wr_i		(tag_dirty_wr),
		.dirty_i		(tag_dirty_val),
		.hit_o			(tag_hit),
		.hit_way_o		(tag_hit_way),
		.victim_way_o		(victim_way),
		.victim_tag_o		(victim_tag),
		.victim_dirty_o		(victim_dirty)
	);

	cache_data_memory #(
		.CACHE_BLOCK_CAPACITY	(CACHE_BLOCK_CAPACITY)
	) u_data_memory (
		.clock_i		(clock_i),
		.addr_i			(mem_addr),
		.wren_i			(mem_wren),
		.data_i			(mem_wdata),
		.data_o			(mem_rdata)
	);

	cache_controller #(
		.CACHE_BLOCK_CAPACITY	(CACHE_BLOCK_CAPACITY),
		.CACHE_SET_SIZE		(CACHE_SET_SIZE)
	) u_controller (
		.clock_i		(clock_i),
		.rst_n_i		(rst_n_i),
		.en_i			(en_i),
		.core_req_i		(core_req_i),
		.core_rw_i		(core_rw_i),
		.core_tag_i		(req_tag),
		.core_set_i		(req_set),
		.core_word_i		(req_word),
		.core_data_i		(core_data_i),
		.core_done_o		(core_done_o),
		.core_data_o		(core_data_o),
		.hit_o			(hit_o),
		.tag_hit_i		(tag_hit),
		.tag_hit_way_i		(tag_hit_way),
		.victim_way_i		(victim_way),
		.victim_tag_i		(victim_tag),
		.victim_dirty_i		(victim_dirty),
		.tag_wren_o		(tag_wren),
		.tag_dirty_wr_o		(tag_dirty_wr),
		.tag_way_o		(tag_way),
		.tag_dirty_val_o	(tag_dirty_val),
		.mem_rdata_i		(mem_rdata),
		.mem_addr_o		(mem_addr),
		.mem_wren_o		(mem_wren),
		.mem_wdata_o		(mem_wdata),
		.ready_req_i		(ready_req_i),
		.ready_write_i		(ready_write_i),
		.ready_read_i		(ready_read_i),
		.data_i			(data_i),
		.req_o			(req_o),
		.rw_o			(rw_o),
		.write_o		(write_o),
		.read_o			(read_o),
		.add_o			(add_o),
		.data_o			(data_o),
		.flag_hit_o		(flag_hit),
		.flag_miss_o		(flag_miss),
		.flag_wb_o		(flag_wb)
	);

	cache_perf_counter u_perf_counter (
		.clock_i		(clock_i),
		.rst_n_i		(rst_n_i),
		.hit_i			(flag_hit),
		.miss_i			(flag_miss),
		.writeback_i		(flag_wb),
		.comm_i			(comm_i),
		.comm_o			(comm_o)
	);

endmodule

`default_nettype wire

//--- dv/cache_buffer_model.sv
`timescale 1ns/1ps
`default_nettype none

module cache_buffer_model #(
	parameter logic [31:0] SEED = 32'h6c4c_7e16
)(
	input  wire         clock_i,
	input  wire         rst_n_i,
	input  wire         req_i,			// block command from the cache
	input  wire  [15:0] add_i,			// block aligned
	input  wire         write_i,
	input  wire         read_i,
	input  wire  [31:0] data_i,			// writeback word
	output logic        ready_req_o,
	output logic        ready_write_o,
	output logic        ready_read_o,
	output logic [31:0] data_o			// fill word, valid with read_i
);

	logic [31:0] mem [65536];
	logic [31:0] rng = SEED;
	logic [15:0] base = '0;			// block of the last accepted command
	logic [1:0]  beat = '0;			// word inside that block
	logic        cmd_seen, wr_seen, rd_seen;
	logic [15:0] add_seen;
	logic [31:0] wdata_seen;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	initial begin
		ready_req_o   = 1'b0;
		ready_write_o = 1'b0;
		ready_read_o  = 1'b0;
		for (int i = 0; i < 65536; i++)
			mem[i[15:0]] = {16'hc0de, i[15:0]};	// untouched words carry their address
	end

	assign data_o = mem[base | {14'd0, beat}];

	// sample at the edge, update a little later
	always @(posedge clock_i) begin
		cmd_seen   = req_i && ready_req_o;
		wr_seen    = write_i;
		rd_seen    = read_i;
		add_seen   = add_i;
		wdata_seen = data_i;
		#1;
		if (rst_n_i) begin
			if (cmd_seen) begin
				base = add_seen;
				beat = '0;
			end
			if (wr_seen) begin
				mem[base | {14'd0, beat}] = wdata_seen;
				beat = beat + 2'd1;
			end
			if (rd_seen)
				beat = beat + 2'd1;
			rng           = xorshift(rng);
			ready_req_o   = rng[1:0] != 2'b00;	// roughly 3 in 4 cycles ready
			ready_write_o = rng[4:3] != 2'b00;
			ready_read_o  = rng[7:6] != 2'b00;
		end
	end

endmodule

`default_nettype wire

//--- dv/cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cache_tb;

	localparam int CLK_PERIOD = 8;
	localparam int N_ACCESS   = 11;		// core accesses over all tests
	localparam int N_SET      = 4;		// 16 blocks in 4 ways

	logic        clk = 1'b0;
	logic        rst_n = 1'b0;
	logic        en = 1'b1;
	logic [31:0] comm_in = '0;
	logic        core_req = 1'b0;
	logic        core_rw = 1'b0;
	logic [15:0] core_add = '0;
	logic [31:0] core_wdata = '0;
	logic [31:0] comm_out, core_rdata, buf_rdata, buf_wdata;
	logic        core_done, hit, ready_req, ready_write, ready_read;
	logic        req, rw, wr, rd;
	logic [15:0] buf_add;

	// reference state
	// ----------------------------------------------------------
	logic [31:0] ref_mem   [65536];		// latest value of every word
	logic [11:0] ref_tag   [N_SET][4];
	logic        ref_valid [N_SET][4];
	logic        ref_dirty [N_SET][4];
	logic [1:0]  ref_rr    [N_SET];
	logic [16:0] cmd_q [$];			// {rw, add} per accepted command
	logic [31:0] wb_q  [$];
	int exp_hits = 0, exp_misses = 0, exp_wbs = 0;
	int err_cnt = 0, check_cnt = 0, test_cnt = 0, test_err = 0;

	always #(CLK_PERIOD / 2) clk = ~clk;

	cache_n_set #(
		.CACHE_BLOCK_CAPACITY	(16),
		.CACHE_SET_SIZE		(4)
	) u_dut (
		.clock_i(clk), .rst_n_i(rst_n), .en_i(en), .comm_i(comm_in), .comm_o(comm_out),
		.core_req_i(core_req), .core_rw_i(core_rw), .core_add_i(core_add),
		.core_data_i(core_wdata), .core_done_o(core_done), .core_data_o(core_rdata),
		.hit_o(hit), .ready_req_i(ready_req), .ready_write_i(ready_write),
		.ready_read_i(ready_read), .data_i(buf_rdata), .req_o(req), .rw_o(rw),
		.write_o(wr), .read_o(rd), .add_o(buf_add), .data_o(buf_wdata)
	);

	cache_buffer_model #(.SEED(32'h6c4c_7e16)) u_buffer (
		.clock_i(clk), .rst_n_i(rst_n), .req_i(req), .add_i(buf_add),
		.write_i(wr), .read_i(rd), .data_i(buf_wdata), .ready_req_o(ready_req),
		.ready_write_o(ready_write), .ready_read_o(ready_read), .data_o(buf_rdata)
	);

	// log buffer traffic as the buffer accepts it
	always @(posedge clk) begin
		if (rst_n && req && ready_req)
			cmd_q.push_back({rw, buf_add});
		if (rst_n && wr)
			wb_q.push_back(buf_wdata);
	end

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
		check_cnt++;
		assert (got === want) else begin
			$display("mismatch %s: got %h, expected %h", name, got, want);
			err_cnt++;
		end
	endtask

	task automatic check_true(input string what, input bit cond);
		check_cnt++;
		assert (cond) else begin
			$display("error: %s", what);
			err_cnt++;
		end
	endtask

	task automatic end_test(input string name);
		test_cnt++;
		if (err_cnt == test_err)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, err_cnt - test_err);
		test_err = err_cnt;
	endtask

	task automatic expect_cmd(input logic cmd_rw, input logic [15:0] cmd_add);
		logic [16:0] got;
		check_true("no buffer command was accepted", cmd_q.size() != 0);
		if (cmd_q.size() != 0) begin
			got = cmd_q.pop_front();
			check_val("rw_o", 32'(got[16]), 32'(cmd_rw));
			check_val("add_o", 32'(got[15:0]), 32'(cmd_add));
		end
	endtask

	// one core access predicted by the reference and then checked
	// ----------------------------------------------------------
	task automatic core_access(input logic acc_rw, input logic [15:0] addr,
			input logic [31:0] wdata);
		logic [1:0]  set;
		logic [1:0]  way;
		logic [11:0] tag;
		logic [15:0] vic_add;
		logic        exp_hit;
		logic        exp_wb;
		logic        got_hit;
		logic [31:0] got_data;
		int          lat;
		set     = addr[3:2];
		tag     = addr[15:4];
		exp_hit = 1'b0;
		exp_wb  = 1'b0;
		way     = '0;
		vic_add = '0;
		for (int w = 0; w < 4; w++) begin
			if (ref_valid[set][w[1:0]] && ref_tag[set][w[1:0]] == tag) begin
				exp_hit = 1'b1;
				way     = w[1:0];
			end
		end
		if (exp_hit) begin
			exp_hits++;
		end else begin
			way                 = ref_rr[set];	// round-robin victim
			exp_wb              = ref_valid[set][way] && ref_dirty[set][way];
			vic_add             = {ref_tag[set][way], set, 2'b00};
			ref_tag[set][way]   = tag;
			ref_valid[set][way] = 1'b1;
			ref_dirty[set][way] = 1'b0;
			ref_rr[set]         = ref_rr[set] + 2'd1;
			exp_misses++;
			if (exp_wb)
				exp_wbs++;
		end
		if (acc_rw)
			ref_dirty[set][way] = 1'b1;
		@(posedge clk);
		#1;
		core_req   = 1'b1;
		core_rw    = acc_rw;
		core_add   = addr;
		core_wdata = wdata;
		@(posedge clk);		// request sampled here
		lat = 0;
		do begin
			@(negedge clk);
			lat++;
		end while (!core_done);
		got_hit  = hit;
		got_data = core_rdata;
		@(posedge clk);
		#1;
		core_req = 1'b0;
		check_val("hit_o", 32'(got_hit), 32'(exp_hit));
		if (exp_hit)
			check_val("hit latency", 32'(lat), 32'd2);	// lookup then respond
		if (!acc_rw)
			check_val("core_data_o", got_data, ref_mem[addr]);
		if (exp_wb) begin
			expect_cmd(1'b1, vic_add);
			for (int i = 0; i < 4; i++) begin
				check_true("a writeback word did not reach the buffer", wb_q.size() != 0);
				if (wb_q.size() != 0)
					check_val("data_o", wb_q.pop_front(), ref_mem[vic_add | 16'(i)]);
			end
		end
		if (!exp_hit)
			expect_cmd(1'b0, {addr[15:2], 2'b00});
		check_val("extra buffer commands", 32'(cmd_q.size()), 32'd0);
		check_val("extra writeback words", 32'(wb_q.size()), 32'd0);
		if (acc_rw)
			ref_mem[addr] = wdata;
	endtask

	task automatic comm_cmd(input logic [3:0] op, input logic [1:0] sel);
		@(posedge clk);
		#1;
		comm_in = {op, 26'd0, sel};
		@(posedge clk);		// taken at this edge
		#1;
		comm_in = '0;		// no-op so the readback holds
	endtask

	task automatic read_counter(input string name, input logic [1:0] sel, input int want);
		comm_cmd(cache_pkg::COMM_OP_READ, sel);
		@(negedge clk);
		check_val(name, comm_out, 32'(want));
	endtask

	// tests
	// ----------------------------------------------------------
	initial begin
		for (int i = 0; i < 65536; i++)
			ref_mem[i[15:0]] = {16'hc0de, i[15:0]};
		for (int s = 0; s < N_SET; s++) begin
			ref_rr[s[1:0]] = '0;
			for (int w = 0; w < 4; w++) begin
				ref_tag[s[1:0]][w[1:0]]   = '0;
				ref_valid[s[1:0]][w[1:0]] = 1'b0;
				ref_dirty[s[1:0]][w[1:0]] = 1'b0;
			end
		end
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(negedge clk);
		check_val("core_done_o", 32'(core_done), 32'd0);
		check_val("hit_o", 32'(hit), 32'd0);
		check_val("req_o", 32'(req), 32'd0);
		check_val("write_o", 32'(wr), 32'd0);
		check_val("read_o", 32'(rd), 32'd0);
		check_val("comm_o", comm_out, 32'd0);
		end_test("reset");
		core_access(1'b0, 16'h0120, '0);
		end_test("read_miss");
		core_access(1'b0, 16'h0123, '0);		// same block
		end_test("read_hit");
		core_access(1'b1, 16'h0121, 32'hdead_beef);	// write hit makes the block dirty
		core_access(1'b0, 16'h0121, '0);
		core_access(1'b1, 16'h0234, 32'h1234_5678);	// write miss in set 1
		core_access(1'b0, 16'h0234, '0);
		end_test("write_read");
		// tags 013..016 fill set 0 and the last one pushes out dirty 012
		core_access(1'b0, 16'h0130, '0);
		core_access(1'b0, 16'h0142, '0);
		core_access(1'b0, 16'h0151, '0);
		core_access(1'b0, 16'h0163, '0);
		core_access(1'b0, 16'h0121, '0);		// refetch from the buffer
		end_test("eviction");
		read_counter("comm_o hits", cache_pkg::COMM_SEL_HIT, exp_hits);
		read_counter("comm_o misses", cache_pkg::COMM_SEL_MISS, exp_misses);
		read_counter("comm_o writebacks", cache_pkg::COMM_SEL_WB, exp_wbs);
		comm_cmd(cache_pkg::COMM_OP_CLEAR, 2'd0);
		read_counter("comm_o hits", cache_pkg::COMM_SEL_HIT, 0);
		read_counter("comm_o misses", cache_pkg::COMM_SEL_MISS, 0);
		read_counter("comm_o writebacks", cache_pkg::COMM_SEL_WB, 0);
		end_test("counters");
		$display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	// watchdog allows 200 cycles per access plus some slack
	initial begin
		#((N_ACCESS * 200 + 100) * CLK_PERIOD);
		$display("timeout: the tests did not finish in time");
		$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
source/cache_pkg.sv
source/cache_tag_memory.sv
source/cache_data_memory.sv
source/cache_controller.sv
source/cache_perf_counter.sv
source/cache_n_set.sv
dv/cache_buffer_model.sv
dv/cache_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the cache testbench with Verilator

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f tb.f --top-module cache_tb -o cache_tb_sim \
	|| { echo "build failed"; exit 1; }

./obj_dir/cache_tb_sim | tee /dev/stderr | grep -q "Verification passed" \
	&& echo "run.sh: simulation ok" \
	|| { echo "run.sh: simulation not ok"; exit 1; }
